// ==== hw/nco_macros.svh ====
/* NCO width and register address macros
   shared by the package and every RTL block */

`ifndef NCO_MACROS_SVH
`define NCO_MACROS_SVH

// one period half, also one host register word
`define NCO_DATA_W 16

// fractional bits of the fixed-point period
`define NCO_FRAC_W `NCO_DATA_W

// integer half above the fractional half
`define NCO_PERIOD_W (2 * `NCO_DATA_W)

// four host registers
`define NCO_ADDR_W 2

`endif

// ==== hw/nco_pkg.sv ====
/* NCO package with the fixed-point period word
   and the host register map */

`include "nco_macros.svh"

package nco_pkg;

   // integer half sits above the fractional half
   typedef struct packed {
      logic [`NCO_DATA_W-1:0] int_part;
      logic [`NCO_FRAC_W-1:0] frac_part;
   } nco_period_s;

   // register bank fills the halves, accumulator adds the word
   typedef union packed {
      logic [`NCO_PERIOD_W-1:0] word;
      nco_period_s              half;
   } nco_period_u;

   // host register addresses
   typedef enum logic [`NCO_ADDR_W-1:0] {
      NCO_CTRL     = 2'd0,
      NCO_PER_INT  = 2'd1,
      NCO_PER_FRAC = 2'd2,
      NCO_STATUS   = 2'd3
   } nco_addr_e;

endpackage

// ==== hw/nco_cfg_if.sv ====
/* NCO configuration bus from the register bank to the modulator core */

`timescale 1ns/1ps

interface nco_cfg_if
   import nco_pkg::*;
();

   // one-cycle pulse that clears the core
   logic        soft_reset;
   // core runs while high
   logic        enable;
   // committed fixed-point period, valid with period_load
   nco_period_u period;
   // one-cycle pulse once both halves are written
   logic        period_load;

   modport csr (
      output soft_reset,
      output enable,
      output period,
      output period_load
   );

   modport core (
      input soft_reset,
      input enable,
      input period,
      input period_load
   );

endinterface

// ==== hw/nco_csr.sv ====
/* NCO register bank: control, period halves with paired commit,
   status, and a combinational read port */

`timescale 1ns/1ps
`include "nco_macros.svh"

module nco_csr
   import nco_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   wen_i,
   input  logic [`NCO_ADDR_W-1:0] addr_i,
   input  logic [`NCO_DATA_W-1:0] wdata_i,
   output logic [`NCO_DATA_W-1:0] rdata_o,
   nco_cfg_if.csr                 cfg
);

   logic        enable_q;
   logic        soft_reset_q;
   logic        pend_int_q;
   logic        pend_frac_q;
   logic        commit;
   logic        wr_ctrl;
   logic        wr_int;
   logic        wr_frac;
   nco_period_u period_q;

   // write decode
   assign wr_ctrl = wen_i && (addr_i == NCO_CTRL);
   assign wr_int  = wen_i && (addr_i == NCO_PER_INT);
   assign wr_frac = wen_i && (addr_i == NCO_PER_FRAC);

   // both halves in, so the pair goes to the core this cycle
   assign commit = pend_int_q & pend_frac_q;

   // control register
   // soft reset bit is never stored, it only fires one pulse
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable_q     <= 1'b0;
         soft_reset_q <= 1'b0;
      end else if (wr_ctrl) begin
         // a soft reset write also drops enable at once
         enable_q     <= wdata_i[0] & ~wdata_i[1];
         soft_reset_q <= wdata_i[1];
      end else begin
         soft_reset_q <= 1'b0;
      end
   end

   // period halves
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_q) begin
         period_q.word <= '0;
      end else begin
         if (wr_int) begin
            period_q.half.int_part <= wdata_i;
         end
         if (wr_frac) begin
            period_q.half.frac_part <= wdata_i;
         end
      end
   end

   // pending flags, one per half
   // a commit clears both, a write in the same cycle starts a new pair
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_q) begin
         pend_int_q  <= 1'b0;
         pend_frac_q <= 1'b0;
      end else begin
         pend_int_q  <= (pend_int_q & ~commit) | wr_int;
         pend_frac_q <= (pend_frac_q & ~commit) | wr_frac;
      end
   end

   // read port
   always_comb begin
      rdata_o = '0;
      case (nco_addr_e'(addr_i))
         NCO_CTRL: begin
            rdata_o[0] = enable_q;
         end
         NCO_PER_INT: begin
            rdata_o = period_q.half.int_part;
         end
         NCO_PER_FRAC: begin
            rdata_o = period_q.half.frac_part;
         end
         NCO_STATUS: begin
            // one half written, other still missing
            rdata_o[0] = pend_int_q ^ pend_frac_q;
         end
         default: begin
            rdata_o = '0;
         end
      endcase
   end

   // configuration bus to the core
   assign cfg.soft_reset  = soft_reset_q;
   assign cfg.enable      = enable_q;
   assign cfg.period      = period_q;
   assign cfg.period_load = commit;

endmodule

// ==== hw/nco_phase_acc.sv ====
/* NCO phase accumulator: keeps the committed period plus the carried
   rounding error, and rounds it to a whole cycle count */

`timescale 1ns/1ps
`include "nco_macros.svh"

module nco_phase_acc
   import nco_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   soft_reset_i,
   input  logic                   load_i,
   input  logic                   step_i,
   input  nco_period_u            period_i,
   output logic [`NCO_DATA_W-1:0] quant_o
);

   nco_period_u              period_q;
   nco_period_u              acc_q;
   logic [`NCO_DATA_W-1:0]   int_part;
   logic [`NCO_FRAC_W-1:0]   frac_part;
   logic                     tie;
   logic                     round_up;
   logic [`NCO_PERIOD_W-1:0] step_word;

   assign int_part  = acc_q.half.int_part;
   assign frac_part = acc_q.half.frac_part;

   // fraction exactly one half
   assign tie = (frac_part == {1'b1, {(`NCO_FRAC_W-1){1'b0}}});

   // round to nearest
   // on a tie, round up when the integer part has odd parity
   always_comb begin
      if (tie) begin
         round_up = ^int_part;
      end else begin
         round_up = frac_part[`NCO_FRAC_W-1];
      end
   end

   assign quant_o = int_part + {{(`NCO_DATA_W-1){1'b0}}, round_up};

   // period minus the count just used, as a fixed-point word
   assign step_word = period_q.word - {quant_o, {`NCO_FRAC_W{1'b0}}};

   // the committed period is kept here, so a single half write
   // in the register bank does not reach the output
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         period_q.word <= '0;
         acc_q.word    <= '0;
      end else if (load_i) begin
         period_q <= period_i;
         acc_q    <= period_i;
      end else if (step_i) begin
         // residue stays within half a cycle
         acc_q.word <= acc_q.word + step_word;
      end
   end

endmodule

// ==== hw/nco_clk_gen.sv ====
/* NCO clock generator: modulo counter against the quantized period,
   with a registered half-period compare as the output clock */

`timescale 1ns/1ps
`include "nco_macros.svh"

module nco_clk_gen (
   input  logic    clk_i,
   input  logic    reset_i,
   nco_cfg_if.core cfg,
   output logic    clk_o
);

   logic [`NCO_DATA_W-1:0] quant;
   logic [`NCO_DATA_W-1:0] cnt_q;
   logic [`NCO_DATA_W:0]   cnt_inc;
   logic                   wrap;
   logic                   step;
   logic                   clk_int;

   nco_phase_acc u_phase_acc (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .soft_reset_i(cfg.soft_reset),
      .load_i      (cfg.period_load),
      .step_i      (step),
      .period_i    (cfg.period),
      .quant_o     (quant)
   );

   // one extra bit so the compare never overflows
   assign cnt_inc = {1'b0, cnt_q} + (`NCO_DATA_W + 1)'(1);

   // last cycle of the current output period
   assign wrap = (cnt_inc >= {1'b0, quant});

   // accumulator moves once per output period
   assign step = cfg.enable & wrap;

   // high in the second half of the count
   assign clk_int = (cnt_q > (quant >> 1));

   // modulo counter
   always_ff @(posedge clk_i) begin
      if (reset_i || cfg.soft_reset || cfg.period_load) begin
         cnt_q <= '0;
      end else if (cfg.enable) begin
         if (wrap) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_inc[`NCO_DATA_W-1:0];
         end
      end
   end

   // output clock, held while disabled
   always_ff @(posedge clk_i) begin
      if (reset_i || cfg.soft_reset) begin
         clk_o <= 1'b0;
      end else if (cfg.enable) begin
         clk_o <= clk_int;
      end
   end

endmodule

// ==== hw/nco_top.sv ====
/* NCO top level: host register bank feeding the fractional
   clock divider core over the configuration bus */

`timescale 1ns/1ps
`include "nco_macros.svh"

module nco_top (
   // system
   input  logic                   clk_i,
   input  logic                   reset_i,

   // host write side
   input  logic                   wen_i,
   input  logic [`NCO_ADDR_W-1:0] addr_i,
   input  logic [`NCO_DATA_W-1:0] wdata_i,

   // host read side, selected by addr_i
   output logic [`NCO_DATA_W-1:0] rdata_o,

   // divided clock
   output logic                   clk_o
);

   // configuration bus between bank and core
   nco_cfg_if cfg_bus ();

   // host registers
   nco_csr u_csr (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .wen_i  (wen_i),
      .addr_i (addr_i),
      .wdata_i(wdata_i),
      .rdata_o(rdata_o),
      .cfg    (cfg_bus.csr)
   );

   // modulator core
   nco_clk_gen u_clk_gen (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .cfg    (cfg_bus.core),
      .clk_o  (clk_o)
   );

endmodule

// ==== tests/nco_tb.sv ====
/* NCO testbench: drives the host register port of nco_top, models the
   quantized period sequence and checks every rising edge spacing of clk_o */

`timescale 1ns/1ps
`include "nco_macros.svh"

module nco_tb
   import nco_pkg::*;
();

   logic                   clk_i = 1'b0;
   logic                   reset_i;
   logic                   wen_i;
   logic [`NCO_ADDR_W-1:0] addr_i;
   logic [`NCO_DATA_W-1:0] wdata_i;
   logic [`NCO_DATA_W-1:0] rdata_o;
   logic                   clk_o;

   // enable as the DUT sees it from CTRL writes
   logic        run_en;
   // monitor compares only while set
   logic        mon_on;

   // monitor state with times in enabled cycles only
   logic        clk_o_q;
   logic        have_edge;
   int          active_cnt;
   int          rise_at;
   int          high_len;
   int          gap_idx;
   int unsigned gap_sum;

   // reference sequence of counts and rise spacings
   int unsigned model_q[$];
   int unsigned model_gap[$];

   logic [31:0] lfsr_state = 32'h1d2e21c3;

   logic [`NCO_DATA_W-1:0] ip;
   logic [`NCO_DATA_W-1:0] fp;
   logic [`NCO_DATA_W-1:0] new_int;
   logic [`NCO_DATA_W-1:0] new_frac;
   int unsigned            model_total;
   longint                 track_err;
   int                     run;

   nco_top UUT (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .wen_i  (wen_i),
      .addr_i (addr_i),
      .wdata_i(wdata_i),
      .rdata_o(rdata_o),
      .clk_o  (clk_o)
   );

   always #2 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   // right-shifting galois lfsr
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic int unsigned take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // accumulator rounded to whole cycles with ties up on odd parity
   // spacing between rises is q_k - q_k/2 + q_(k+1)/2
   function automatic void build_model(input logic [31:0] period);
      logic [31:0] acc;
      logic [15:0] int_h;
      logic [15:0] frac_h;
      logic        up;
      int unsigned q;
      model_q.delete();
      model_gap.delete();
      acc = period;
      for (int k = 0; k <= 64; k++) begin
         int_h  = acc[31:16];
         frac_h = acc[15:0];
         if (frac_h == 16'h8000) begin
            up = ^int_h;
         end else begin
            up = frac_h[15];
         end
         q = int_h + up;
         model_q.push_back(q);
         acc = acc + period - (q << 16);
      end
      for (int k = 0; k < 64; k++) begin
         model_gap.push_back(model_q[k] - model_q[k] / 2 + model_q[k + 1] / 2);
      end
   endfunction

   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      @(posedge clk_i);
      wen_i   <= 1'b1;
      addr_i  <= addr;
      wdata_i <= data;
      @(posedge clk_i);
      wen_i <= 1'b0;
      // write lands on this edge
      if (addr == NCO_CTRL) begin
         run_en <= data[0] & ~data[1];
      end
   endtask

   task automatic read_expect(input logic [1:0] addr, input logic [15:0] exp,
                              input string name);
      @(posedge clk_i);
      addr_i <= addr;
      @(posedge clk_i);
      check_value(name, 32'(rdata_o), 32'(exp));
   endtask

   task automatic wait_rises(input int count);
      int n;
      n = 0;
      while (gap_idx < count) begin
         @(posedge clk_i);
         n++;
         if (n > 50 * count + 200) begin
            $display("timeout: clk_o rising edge %0d never came", gap_idx + 2);
            $display("Errors found");
            $fatal(1);
         end
      end
   endtask

   task automatic hold_level(input int cycles);
      logic level;
      @(posedge clk_i);
      level = clk_o;
      repeat (cycles) begin
         @(posedge clk_i);
         check_value("clk_o while disabled", 32'(clk_o), 32'(level));
      end
   endtask

   // clean start with a soft reset and both halves committed before enable
   task automatic start_period(input logic [15:0] int_h, input logic [15:0] frac_h);
      mon_on <= 1'b0;
      write_reg(NCO_CTRL, 16'h0002);
      write_reg(NCO_PER_INT, int_h);
      write_reg(NCO_PER_FRAC, frac_h);
      build_model({int_h, frac_h});
      @(posedge clk_i);
      mon_on <= 1'b1;
      write_reg(NCO_CTRL, 16'h0001);
   endtask

   task automatic run_integer(input logic [15:0] v);
      start_period(v, 16'h0000);
      wait_rises(8);
      check_value("clk_o high time", 32'(high_len), 32'(v - 16'd1 - v / 16'd2));
   endtask

   // edge monitor
   always @(posedge clk_i) begin
      if (reset_i) begin
         clk_o_q    <= 1'b0;
         have_edge  <= 1'b0;
         active_cnt <= 0;
         rise_at    <= 0;
         high_len   <= 0;
         gap_idx    <= 0;
         gap_sum    <= 0;
      end else begin
         clk_o_q <= clk_o;
         if (run_en) begin
            active_cnt <= active_cnt + 1;
         end
         if (clk_o && !clk_o_q) begin
            rise_at <= active_cnt;
         end
         if (!clk_o && clk_o_q) begin
            high_len <= active_cnt - rise_at;
         end
         if (!mon_on) begin
            have_edge <= 1'b0;
            gap_idx   <= 0;
            gap_sum   <= 0;
         end else if (clk_o && !clk_o_q) begin
            have_edge <= 1'b1;
            if (have_edge && gap_idx < model_gap.size()) begin
               check_value("clk_o rise spacing", active_cnt - rise_at, model_gap[gap_idx]);
               gap_idx <= gap_idx + 1;
               gap_sum <= gap_sum + (active_cnt - rise_at);
            end
         end
      end
   end

   initial begin
      reset_i <= 1'b1;
      wen_i   <= 1'b0;
      addr_i  <= '0;
      wdata_i <= '0;
      run_en  <= 1'b0;
      mon_on  <= 1'b0;
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;

      // reset state
      repeat (50) begin
         @(posedge clk_i);
         check_value("clk_o after reset", 32'(clk_o), 32'h0);
      end
      read_expect(NCO_CTRL, 16'h0000, "rdata_o ctrl after reset");
      read_expect(NCO_PER_INT, 16'h0000, "rdata_o per_int after reset");
      read_expect(NCO_PER_FRAC, 16'h0000, "rdata_o per_frac after reset");
      read_expect(NCO_STATUS, 16'h0000, "rdata_o status after reset");

      // readback with the integer half first and then the fraction first
      ip = 16'(take_bits(16));
      fp = 16'(take_bits(16));
      write_reg(NCO_PER_INT, ip);
      read_expect(NCO_STATUS, 16'h0001, "rdata_o status one half");
      write_reg(NCO_PER_FRAC, fp);
      read_expect(NCO_STATUS, 16'h0000, "rdata_o status pair");
      read_expect(NCO_PER_INT, ip, "rdata_o per_int");
      read_expect(NCO_PER_FRAC, fp, "rdata_o per_frac");
      ip = 16'(take_bits(16));
      fp = 16'(take_bits(16));
      write_reg(NCO_PER_FRAC, fp);
      read_expect(NCO_STATUS, 16'h0001, "rdata_o status one half");
      write_reg(NCO_PER_INT, ip);
      read_expect(NCO_STATUS, 16'h0000, "rdata_o status pair");
      read_expect(NCO_PER_INT, ip, "rdata_o per_int");
      read_expect(NCO_PER_FRAC, fp, "rdata_o per_frac");

      // odd and even integer periods
      run_integer(16'd3);
      run_integer(16'd4);
      run_integer(16'd7);
      run_integer(16'd10);
      run_integer(16'd25);

      // fractional periods start at 3 since a count of 2 never rises above its half
      for (run = 0; run < 20; run++) begin
         ip = 16'(3 + take_bits(6) % 38);
         fp = 16'(take_bits(16));
         start_period(ip, fp);
         wait_rises(30);
         model_total = 0;
         for (int k = 0; k < 30; k++) begin
            model_total += model_gap[k];
         end
         check_value("clk_o spacing sum", gap_sum, model_total);
         track_err = longint'(gap_sum) * 65536 - 30 * longint'({ip, fp});
         if (track_err < 0) begin
            track_err = -track_err;
         end
         check_value("average period error", 32'(track_err > 2 * 65536), 32'h0);
      end

      // a lone half write must not reach the core
      new_int = (ip == 16'd40) ? 16'd3 : ip + 16'd1;
      write_reg(NCO_PER_INT, new_int);
      read_expect(NCO_STATUS, 16'h0001, "rdata_o status one half");
      wait_rises(40);

      // gating holds the output, then the sequence resumes
      write_reg(NCO_CTRL, 16'h0000);
      hold_level(40);
      write_reg(NCO_CTRL, 16'h0001);
      wait_rises(50);

      // completing the pair while stopped starts the new period
      write_reg(NCO_CTRL, 16'h0000);
      mon_on   <= 1'b0;
      new_frac = 16'(take_bits(16));
      write_reg(NCO_PER_FRAC, new_frac);
      @(posedge clk_i);
      build_model({new_int, new_frac});
      mon_on <= 1'b1;
      write_reg(NCO_CTRL, 16'h0001);
      wait_rises(20);

      // soft reset while running
      mon_on <= 1'b0;
      write_reg(NCO_CTRL, 16'h0003);
      @(posedge clk_i);
      repeat (40) begin
         @(posedge clk_i);
         check_value("clk_o after soft reset", 32'(clk_o), 32'h0);
      end
      read_expect(NCO_CTRL, 16'h0000, "rdata_o ctrl after soft reset");
      read_expect(NCO_PER_INT, 16'h0000, "rdata_o per_int after soft reset");
      read_expect(NCO_PER_FRAC, 16'h0000, "rdata_o per_frac after soft reset");
      read_expect(NCO_STATUS, 16'h0000, "rdata_o status after soft reset");

      $display("No errors");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/nco_pkg.sv
hw/nco_cfg_if.sv
hw/nco_csr.sv
hw/nco_phase_acc.sv
hw/nco_clk_gen.sv
hw/nco_top.sv
tests/nco_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := nco_tb
RTL_TOP  := nco_top
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FLAGS    := --binary --timing -Mdir $(OBJ_DIR)
LINT     := --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# the log decides the result
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "Errors found" $(LOG); then \
		exit 1; \
	fi; \
	if ! grep -q "No errors" $(LOG); then \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
